/* common/dma_node_pkg.sv */
// shared widths, memory window and job/response records of the DMA node
// imported by the RTL and by the testbench

package dma_node_pkg;

  // bus and job widths
  localparam int unsigned AddrWidth    = 16;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned LenWidth     = 8;

  // local memory window, in words
  localparam logic [AddrWidth-1:0] MemBase = 16'h0000;
  localparam int unsigned MemWords     = 256;
  localparam int unsigned MemAddrWidth = $clog2(MemWords);

  // depth of the job queue and of the response queue
  localparam int unsigned FifoDepth    = 4;

  typedef enum logic [1:0] {
    STATUS_OK       = 2'd0,
    STATUS_BUS_ERR  = 2'd1,
    STATUS_ZERO_LEN = 2'd2
  } dma_status_e;

  // one copy job
  typedef struct packed {
    logic [AddrWidth-1:0] src;
    logic [AddrWidth-1:0] dst;
    logic [LenWidth-1:0]  len;
  } dma_job_t;

  // result of one job, addr is the last or the failing address
  typedef struct packed {
    dma_status_e          status;
    logic [AddrWidth-1:0] addr;
  } dma_rsp_t;

endpackage

/* dma/dma_fifo.sv */
`timescale 1ns/100ps
// synchronous FIFO with valid/ready on both sides
// the payload type is chosen per instance (jobs or responses)

module dma_fifo #(
  parameter type         dma_payload_t = logic,
  parameter int unsigned Depth         = dma_node_pkg::FifoDepth
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  dma_payload_t push_data_i,
  input  logic         push_valid_i,
  output logic         push_ready_o,
  output dma_payload_t pop_data_o,
  output logic         pop_valid_o,
  input  logic         pop_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  dma_payload_t        buf_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // a full queue still accepts when the head leaves in the same cycle
  assign push_ready_o = (count_q != CntWidth'(Depth)) || pop_ready_i;
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = buf_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* dma/dma_backend.sv */
`timescale 1ns/100ps
// copy engine of the DMA node
// takes one job at a time, moves it word by word over the request/grant
// bus (read, then write) and hands a status record to the response queue

module dma_backend (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  dma_node_pkg::dma_job_t            job_i,
  input  logic                              job_valid_i,
  output logic                              job_ready_o,
  output dma_node_pkg::dma_rsp_t            rsp_o,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic                              bus_req_o,
  output logic                              bus_we_o,
  output logic [dma_node_pkg::AddrWidth-1:0] bus_addr_o,
  output logic [dma_node_pkg::DataWidth-1:0] bus_wdata_o,
  input  logic                              bus_gnt_i,
  input  logic                              bus_rvalid_i,
  input  logic [dma_node_pkg::DataWidth-1:0] bus_rdata_i,
  input  logic                              bus_err_i
);

  import dma_node_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_RD,
    WRITE,
    WAIT_WR,
    RESP
  } state_e;

  state_e               state_q;
  logic [AddrWidth-1:0] src_q;
  logic [AddrWidth-1:0] dst_q;
  logic [LenWidth-1:0]  remain_q;
  logic [DataWidth-1:0] data_q;
  dma_rsp_t             rsp_q;

  // ----------------------------------------------------------
  // handshakes and bus drive
  // ----------------------------------------------------------

  assign job_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESP);
  assign rsp_o       = rsp_q;

  assign bus_req_o   = (state_q == READ) || (state_q == WRITE);
  assign bus_we_o    = (state_q == WRITE);
  assign bus_addr_o  = (state_q == WRITE) ? dst_q : src_q;
  assign bus_wdata_o = data_q;

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          // zero length goes straight to the response
          if (job_valid_i) begin
            state_q <= (job_i.len == '0) ? RESP : READ;
          end
        end
        READ: begin
          if (bus_gnt_i) state_q <= WAIT_RD;
        end
        WAIT_RD: begin
          if (bus_rvalid_i) state_q <= bus_err_i ? RESP : WRITE;
        end
        WRITE: begin
          if (bus_gnt_i) state_q <= WAIT_WR;
        end
        WAIT_WR: begin
          if (bus_rvalid_i) begin
            state_q <= (bus_err_i || remain_q == LenWidth'(1)) ? RESP : READ;
          end
        end
        RESP: begin
          // held here while the response queue is full
          if (rsp_ready_i) state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // address counters, data and result
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: begin
        if (job_valid_i) begin
          src_q    <= job_i.src;
          dst_q    <= job_i.dst;
          remain_q <= job_i.len;
          rsp_q    <= '{status: STATUS_ZERO_LEN, addr: job_i.src};
        end
      end
      WAIT_RD: begin
        if (bus_rvalid_i) begin
          data_q <= bus_rdata_i;
          if (bus_err_i) begin
            rsp_q <= '{status: STATUS_BUS_ERR, addr: src_q};
          end
        end
      end
      WAIT_WR: begin
        if (bus_rvalid_i) begin
          rsp_q <= '{status: bus_err_i ? STATUS_BUS_ERR : STATUS_OK, addr: dst_q};
          if (!bus_err_i) begin
            src_q    <= src_q + 1'b1;
            dst_q    <= dst_q + 1'b1;
            remain_q <= remain_q - 1'b1;
          end
        end
      end
      default: begin
      end
    endcase
  end

endmodule

/* design/dma_addr_demux.sv */
`timescale 1ns/100ps
// routes each backend access to local memory or to the external master
// port and merges the single returning response

module dma_addr_demux (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // backend side
  input  logic                                 bus_req_i,
  input  logic                                 bus_we_i,
  input  logic [dma_node_pkg::AddrWidth-1:0]    bus_addr_i,
  input  logic [dma_node_pkg::DataWidth-1:0]    bus_wdata_i,
  output logic                                 bus_gnt_o,
  output logic                                 bus_rvalid_o,
  output logic [dma_node_pkg::DataWidth-1:0]    bus_rdata_o,
  output logic                                 bus_err_o,
  // local memory
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic [dma_node_pkg::MemAddrWidth-1:0] mem_addr_o,
  output logic [dma_node_pkg::DataWidth-1:0]    mem_wdata_o,
  input  logic [dma_node_pkg::DataWidth-1:0]    mem_rdata_i,
  // external master port
  output logic                                 ext_req_o,
  output logic                                 ext_we_o,
  output logic [dma_node_pkg::AddrWidth-1:0]    ext_addr_o,
  output logic [dma_node_pkg::DataWidth-1:0]    ext_wdata_o,
  input  logic                                 ext_gnt_i,
  input  logic                                 ext_rvalid_i,
  input  logic [dma_node_pkg::DataWidth-1:0]    ext_rdata_i,
  input  logic                                 ext_err_i
);

  import dma_node_pkg::*;

  logic [AddrWidth-1:0] offset;
  logic                 is_local;
  logic                 local_rv_q;
  logic                 ext_pend_q;

  // below MemBase the offset wraps, so one compare covers both ends
  assign offset   = bus_addr_i - MemBase;
  assign is_local = (offset < MemWords);

  assign mem_req_o   = bus_req_i && is_local;
  assign mem_we_o    = bus_we_i;
  assign mem_addr_o  = offset[MemAddrWidth-1:0];
  assign mem_wdata_o = bus_wdata_i;

  assign ext_req_o   = bus_req_i && !is_local;
  assign ext_we_o    = bus_we_i;
  assign ext_addr_o  = bus_addr_i;
  assign ext_wdata_o = bus_wdata_i;

  // memory grants at once; external grant passes through
  assign bus_gnt_o = mem_req_o || (ext_req_o && ext_gnt_i);

  // owner of the outstanding access
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      local_rv_q <= 1'b0;
      ext_pend_q <= 1'b0;
    end else begin
      local_rv_q <= mem_req_o;
      if (ext_req_o && ext_gnt_i) begin
        ext_pend_q <= 1'b1;
      end else if (ext_rvalid_i) begin
        ext_pend_q <= 1'b0;
      end
    end
  end

  assign bus_rvalid_o = local_rv_q || (ext_pend_q && ext_rvalid_i);
  assign bus_rdata_o  = local_rv_q ? mem_rdata_i : ext_rdata_i;
  assign bus_err_o    = !local_rv_q && ext_pend_q && ext_rvalid_i && ext_err_i;

endmodule

/* design/node_mem.sv */
`timescale 1ns/100ps
// dual-port word memory of the node
// port a serves the DMA, port b the inbound slave; read data is registered

module node_mem (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 a_req_i,
  input  logic                                 a_we_i,
  input  logic [dma_node_pkg::MemAddrWidth-1:0] a_addr_i,
  input  logic [dma_node_pkg::DataWidth-1:0]    a_wdata_i,
  output logic [dma_node_pkg::DataWidth-1:0]    a_rdata_o,
  input  logic                                 b_req_i,
  input  logic                                 b_we_i,
  input  logic [dma_node_pkg::MemAddrWidth-1:0] b_addr_i,
  input  logic [dma_node_pkg::DataWidth-1:0]    b_wdata_i,
  output logic [dma_node_pkg::DataWidth-1:0]    b_rdata_o,
  output logic                                 b_rvalid_o
);

  import dma_node_pkg::*;

  logic [DataWidth-1:0] mem_q [MemWords];

  always_ff @(posedge clk_i) begin
    if (a_req_i && a_we_i) begin
      mem_q[a_addr_i] <= a_wdata_i;
    end
    // port b comes last, so it wins a same-word collision
    if (b_req_i && b_we_i) begin
      mem_q[b_addr_i] <= b_wdata_i;
    end
    if (a_req_i) begin
      a_rdata_o <= mem_q[a_addr_i];
    end
    if (b_req_i) begin
      b_rdata_o <= mem_q[b_addr_i];
    end
  end

  // inbound response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_rvalid_o <= 1'b0;
    end else begin
      b_rvalid_o <= b_req_i;
    end
  end

endmodule

/* design/dma_node.sv */
`timescale 1ns/100ps
// DMA endpoint node: job queue, copy engine, address demux, local memory
// and response queue; jobs in and responses out use valid/ready

module dma_node (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  // job input
  input  logic [dma_node_pkg::AddrWidth-1:0]    job_src_i,
  input  logic [dma_node_pkg::AddrWidth-1:0]    job_dst_i,
  input  logic [dma_node_pkg::LenWidth-1:0]     job_len_i,
  input  logic                                 job_valid_i,
  output logic                                 job_ready_o,
  // response output
  output dma_node_pkg::dma_status_e            rsp_status_o,
  output logic [dma_node_pkg::AddrWidth-1:0]    rsp_addr_o,
  output logic                                 rsp_valid_o,
  input  logic                                 rsp_ready_i,
  // external master bus
  output logic                                 ext_req_o,
  output logic                                 ext_we_o,
  output logic [dma_node_pkg::AddrWidth-1:0]    ext_addr_o,
  output logic [dma_node_pkg::DataWidth-1:0]    ext_wdata_o,
  input  logic                                 ext_gnt_i,
  input  logic                                 ext_rvalid_i,
  input  logic [dma_node_pkg::DataWidth-1:0]    ext_rdata_i,
  input  logic                                 ext_err_i,
  // inbound slave bus
  input  logic                                 in_req_i,
  input  logic                                 in_we_i,
  input  logic [dma_node_pkg::MemAddrWidth-1:0] in_addr_i,
  input  logic [dma_node_pkg::DataWidth-1:0]    in_wdata_i,
  output logic                                 in_rvalid_o,
  output logic [dma_node_pkg::DataWidth-1:0]    in_rdata_o
);

  import dma_node_pkg::*;

  dma_job_t              job_in;
  dma_job_t              backend_job;
  logic                  backend_job_valid;
  logic                  backend_job_ready;
  dma_rsp_t              backend_rsp;
  logic                  backend_rsp_valid;
  logic                  backend_rsp_ready;
  dma_rsp_t              rsp_out;

  logic                  bus_req;
  logic                  bus_we;
  logic [AddrWidth-1:0]  bus_addr;
  logic [DataWidth-1:0]  bus_wdata;
  logic                  bus_gnt;
  logic                  bus_rvalid;
  logic [DataWidth-1:0]  bus_rdata;
  logic                  bus_err;

  logic                  mem_req;
  logic                  mem_we;
  logic [MemAddrWidth-1:0] mem_addr;
  logic [DataWidth-1:0]  mem_wdata;
  logic [DataWidth-1:0]  mem_rdata;

  assign job_in       = '{src: job_src_i, dst: job_dst_i, len: job_len_i};
  assign rsp_status_o = rsp_out.status;
  assign rsp_addr_o   = rsp_out.addr;

  // ----------------------------------------------------------
  // queues
  // ----------------------------------------------------------

  dma_fifo #(
    .dma_payload_t ( dma_job_t ),
    .Depth         ( FifoDepth )
  ) job_fifo_inst (
    .clk_i        ( clk_i             ),
    .reset_i      ( reset_i           ),
    .push_data_i  ( job_in            ),
    .push_valid_i ( job_valid_i       ),
    .push_ready_o ( job_ready_o       ),
    .pop_data_o   ( backend_job       ),
    .pop_valid_o  ( backend_job_valid ),
    .pop_ready_i  ( backend_job_ready )
  );

  dma_fifo #(
    .dma_payload_t ( dma_rsp_t ),
    .Depth         ( FifoDepth )
  ) rsp_fifo_inst (
    .clk_i        ( clk_i             ),
    .reset_i      ( reset_i           ),
    .push_data_i  ( backend_rsp       ),
    .push_valid_i ( backend_rsp_valid ),
    .push_ready_o ( backend_rsp_ready ),
    .pop_data_o   ( rsp_out           ),
    .pop_valid_o  ( rsp_valid_o       ),
    .pop_ready_i  ( rsp_ready_i       )
  );

  // ----------------------------------------------------------
  // copy engine, routing and memory
  // ----------------------------------------------------------

  dma_backend backend_inst (
    .clk_i        ( clk_i             ),
    .reset_i      ( reset_i           ),
    .job_i        ( backend_job       ),
    .job_valid_i  ( backend_job_valid ),
    .job_ready_o  ( backend_job_ready ),
    .rsp_o        ( backend_rsp       ),
    .rsp_valid_o  ( backend_rsp_valid ),
    .rsp_ready_i  ( backend_rsp_ready ),
    .bus_req_o    ( bus_req           ),
    .bus_we_o     ( bus_we            ),
    .bus_addr_o   ( bus_addr          ),
    .bus_wdata_o  ( bus_wdata         ),
    .bus_gnt_i    ( bus_gnt           ),
    .bus_rvalid_i ( bus_rvalid        ),
    .bus_rdata_i  ( bus_rdata         ),
    .bus_err_i    ( bus_err           )
  );

  dma_addr_demux demux_inst (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .bus_req_i    ( bus_req      ),
    .bus_we_i     ( bus_we       ),
    .bus_addr_i   ( bus_addr     ),
    .bus_wdata_i  ( bus_wdata    ),
    .bus_gnt_o    ( bus_gnt      ),
    .bus_rvalid_o ( bus_rvalid   ),
    .bus_rdata_o  ( bus_rdata    ),
    .bus_err_o    ( bus_err      ),
    .mem_req_o    ( mem_req      ),
    .mem_we_o     ( mem_we       ),
    .mem_addr_o   ( mem_addr     ),
    .mem_wdata_o  ( mem_wdata    ),
    .mem_rdata_i  ( mem_rdata    ),
    .ext_req_o    ( ext_req_o    ),
    .ext_we_o     ( ext_we_o     ),
    .ext_addr_o   ( ext_addr_o   ),
    .ext_wdata_o  ( ext_wdata_o  ),
    .ext_gnt_i    ( ext_gnt_i    ),
    .ext_rvalid_i ( ext_rvalid_i ),
    .ext_rdata_i  ( ext_rdata_i  ),
    .ext_err_i    ( ext_err_i    )
  );

  node_mem mem_inst (
    .clk_i      ( clk_i       ),
    .reset_i    ( reset_i     ),
    .a_req_i    ( mem_req     ),
    .a_we_i     ( mem_we      ),
    .a_addr_i   ( mem_addr    ),
    .a_wdata_i  ( mem_wdata   ),
    .a_rdata_o  ( mem_rdata   ),
    .b_req_i    ( in_req_i    ),
    .b_we_i     ( in_we_i     ),
    .b_addr_i   ( in_addr_i   ),
    .b_wdata_i  ( in_wdata_i  ),
    .b_rdata_o  ( in_rdata_o  ),
    .b_rvalid_o ( in_rvalid_o )
  );

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/100ps
// clock and reset source for the DMA node testbench
// 20 ns clock, reset_o high for the first ResetCycles rising edges

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* tests/tb_dma_node.sv */
`timescale 1ns/100ps
// testbench of the DMA node: drives jobs, models the external memory,
// predicts every response with a reference function and reads local
// memory back through the inbound port at the end

module tb_dma_node;

  import dma_node_pkg::*;

  localparam logic [31:0]          Seed    = 32'h0496b990;
  localparam int unsigned          Timeout = 5000;
  localparam logic [AddrWidth-1:0] ErrBase = 16'hF000;
  localparam int unsigned          ExtWords = 1 << AddrWidth;

  typedef enum int {EXT_IDLE, EXT_GRANT, EXT_ACCESS, EXT_RESP} ext_phase_e;

  logic clk;
  logic reset;

  logic [AddrWidth-1:0]    job_src_i;
  logic [AddrWidth-1:0]    job_dst_i;
  logic [LenWidth-1:0]     job_len_i;
  logic                    job_valid_i;
  logic                    job_ready_o;
  dma_status_e             rsp_status_o;
  logic [AddrWidth-1:0]    rsp_addr_o;
  logic                    rsp_valid_o;
  logic                    rsp_ready_i;
  logic                    ext_req_o;
  logic                    ext_we_o;
  logic [AddrWidth-1:0]    ext_addr_o;
  logic [DataWidth-1:0]    ext_wdata_o;
  logic                    ext_gnt_i;
  logic                    ext_rvalid_i;
  logic [DataWidth-1:0]    ext_rdata_i;
  logic                    ext_err_i;
  logic                    in_req_i;
  logic                    in_we_i;
  logic [MemAddrWidth-1:0] in_addr_i;
  logic [DataWidth-1:0]    in_wdata_i;
  logic                    in_rvalid_o;
  logic [DataWidth-1:0]    in_rdata_o;

  // reference state and bookkeeping
  logic [DataWidth-1:0] local_shadow [MemWords];
  logic [DataWidth-1:0] ext_shadow [ExtWords];
  logic [DataWidth-1:0] ext_mem [ExtWords];
  dma_rsp_t             exp_q [$];
  logic [31:0]          stim_lfsr = Seed;
  int unsigned          ready_mode = 0;
  int unsigned          err_count = 0;
  int unsigned          fail_count = 0;
  int unsigned          job_count = 0;
  int unsigned          rsp_count = 0;
  int unsigned          ext_access_count = 0;
  logic                 saw_full = 1'b0;

  tb_clk_gen #(.ResetCycles(16)) clk_gen_inst (
    .clk_o   ( clk   ),
    .reset_o ( reset )
  );

  dma_node dma_node_inst (
    .clk_i (clk), .reset_i (reset),
    .job_src_i (job_src_i), .job_dst_i (job_dst_i), .job_len_i (job_len_i),
    .job_valid_i (job_valid_i), .job_ready_o (job_ready_o),
    .rsp_status_o (rsp_status_o), .rsp_addr_o (rsp_addr_o),
    .rsp_valid_o (rsp_valid_o), .rsp_ready_i (rsp_ready_i),
    .ext_req_o (ext_req_o), .ext_we_o (ext_we_o), .ext_addr_o (ext_addr_o),
    .ext_wdata_o (ext_wdata_o), .ext_gnt_i (ext_gnt_i), .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i (ext_rdata_i), .ext_err_i (ext_err_i),
    .in_req_i (in_req_i), .in_we_i (in_we_i), .in_addr_i (in_addr_i),
    .in_wdata_i (in_wdata_i), .in_rvalid_o (in_rvalid_o), .in_rdata_o (in_rdata_o)
  );

  // ----------------------------------------------------------
  // random numbers and reference model
  // ----------------------------------------------------------

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] lfsr_advance(input logic [31:0] state,
                                               input int unsigned steps);
    logic [31:0] s;
    s = state;
    for (int unsigned i = 0; i < steps; i++) begin
      s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    end
    return s;
  endfunction

  function automatic logic [31:0] stim_bits(input int unsigned n);
    stim_lfsr = lfsr_advance(stim_lfsr, n);
    return (n >= 32) ? stim_lfsr : (stim_lfsr & ((32'd1 << n) - 32'd1));
  endfunction

  function automatic logic [DataWidth-1:0] ext_fill(input int unsigned addr);
    return {AddrWidth'(addr) ^ 16'h5aa5, AddrWidth'(addr)};
  endfunction

  function automatic logic in_window(input logic [AddrWidth-1:0] addr);
    return (addr >= MemBase) && (32'(addr) < 32'(MemBase) + MemWords);
  endfunction

  // one job on the shadow memories, word by word: read then write
  function automatic dma_rsp_t apply_job(input dma_job_t job);
    logic [AddrWidth-1:0] s;
    logic [AddrWidth-1:0] d;
    logic [DataWidth-1:0] w;
    if (job.len == '0) return '{status: STATUS_ZERO_LEN, addr: job.src};
    for (int unsigned i = 0; i < job.len; i++) begin
      s = job.src + AddrWidth'(i);
      d = job.dst + AddrWidth'(i);
      if (in_window(s)) w = local_shadow[MemAddrWidth'(s - MemBase)];
      else if (s >= ErrBase) return '{status: STATUS_BUS_ERR, addr: s};
      else w = ext_shadow[s];
      if (in_window(d)) local_shadow[MemAddrWidth'(d - MemBase)] = w;
      else if (d >= ErrBase) return '{status: STATUS_BUS_ERR, addr: d};
      else ext_shadow[d] = w;
    end
    return '{status: STATUS_OK, addr: AddrWidth'(job.dst + job.len - 1'b1)};
  endfunction

  // ----------------------------------------------------------
  // bus tasks
  // ----------------------------------------------------------

  task automatic send_job(input logic [AddrWidth-1:0] src, input logic [AddrWidth-1:0] dst,
                          input logic [LenWidth-1:0] len);
    dma_job_t    job;
    int unsigned t;
    job = '{src: src, dst: dst, len: len};
    @(posedge clk);
    job_src_i   <= src;
    job_dst_i   <= dst;
    job_len_i   <= len;
    job_valid_i <= 1'b1;
    t = 0;
    @(posedge clk);
    while (!job_ready_o && t < Timeout) begin
      saw_full = 1'b1;
      // queues are full, let responses drain at random
      if (ready_mode == 1) ready_mode <= 2;
      @(posedge clk);
      t++;
    end
    job_valid_i <= 1'b0;
    assert (t < Timeout) else begin
      fail_count++;
      $display("timeout: job %h -> %h was never accepted", src, dst);
    end
    if (t < Timeout) begin
      job_count++;
      exp_q.push_back(apply_job(job));
    end
  endtask

  task automatic wait_responses();
    int unsigned t;
    t = 0;
    while (exp_q.size() != 0 && t < Timeout) begin
      @(posedge clk);
      t++;
    end
    assert (exp_q.size() == 0) else begin
      fail_count++;
      $display("timeout: %0d responses still missing", exp_q.size());
    end
    @(posedge clk);
  endtask

  task automatic write_local(input int unsigned addr, input logic [DataWidth-1:0] data);
    @(posedge clk);
    in_req_i   <= 1'b1;
    in_we_i    <= 1'b1;
    in_addr_i  <= MemAddrWidth'(addr);
    in_wdata_i <= data;
  endtask

  task automatic read_local(input int unsigned addr, output logic [DataWidth-1:0] data);
    int unsigned t;
    @(posedge clk);
    in_req_i  <= 1'b1;
    in_we_i   <= 1'b0;
    in_addr_i <= MemAddrWidth'(addr);
    t = 0;
    do begin
      @(posedge clk);
      in_req_i <= 1'b0;
      t++;
    end while (!in_rvalid_o && t < Timeout);
    data = in_rdata_o;
    assert (t < Timeout) else begin
      fail_count++;
      $display("timeout: no inbound read data for word %h", addr);
    end
  endtask

  // ----------------------------------------------------------
  // external memory model and response side
  // ----------------------------------------------------------

  initial begin : ext_model
    logic [31:0]          m_lfsr;
    ext_phase_e           phase;
    int unsigned          cnt;
    logic                 acc_we;
    logic [AddrWidth-1:0] acc_addr;
    logic [DataWidth-1:0] acc_wdata;
    m_lfsr       = lfsr_advance(Seed, 1000);
    phase        = EXT_IDLE;
    cnt          = 0;
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = '0;
    ext_err_i    = 1'b0;
    forever begin
      @(posedge clk);
      ext_gnt_i    <= 1'b0;
      ext_rvalid_i <= 1'b0;
      ext_err_i    <= 1'b0;
      if (phase == EXT_IDLE && ext_req_o && !reset) begin
        m_lfsr = lfsr_advance(m_lfsr, 2);
        cnt    = m_lfsr[1:0];
        phase  = EXT_GRANT;
      end
      if (phase == EXT_GRANT) begin
        if (cnt == 0) begin
          ext_gnt_i <= 1'b1;
          acc_we    = ext_we_o;
          acc_addr  = ext_addr_o;
          acc_wdata = ext_wdata_o;
          ext_access_count++;
          phase     = EXT_ACCESS;
        end else begin
          cnt--;
        end
      end else if (phase == EXT_ACCESS) begin
        if (acc_we && acc_addr < ErrBase) ext_mem[acc_addr] = acc_wdata;
        m_lfsr = lfsr_advance(m_lfsr, 2);
        cnt    = m_lfsr[1:0];
        phase  = EXT_RESP;
      end
      if (phase == EXT_RESP) begin
        if (cnt == 0) begin
          ext_rvalid_i <= 1'b1;
          ext_err_i    <= (acc_addr >= ErrBase);
          ext_rdata_i  <= acc_we ? '0 : ext_mem[acc_addr];
          phase        = EXT_IDLE;
        end else begin
          cnt--;
        end
      end
    end
  end

  // mode 0 always ready, 1 held low, 2 random
  initial begin : drive_rsp_ready
    logic [31:0] r_lfsr;
    r_lfsr      = lfsr_advance(Seed, 2000);
    rsp_ready_i = 1'b1;
    forever begin
      @(posedge clk);
      if (ready_mode == 0) begin
        rsp_ready_i <= 1'b1;
      end else if (ready_mode == 1) begin
        rsp_ready_i <= 1'b0;
      end else begin
        r_lfsr = lfsr_advance(r_lfsr, 1);
        rsp_ready_i <= r_lfsr[0];
      end
    end
  end

  initial begin : compare_responses
    dma_rsp_t exp;
    forever begin
      @(negedge clk);
      if (!reset && rsp_valid_o && rsp_ready_i) begin
        rsp_count++;
        assert (exp_q.size() != 0) else begin
          fail_count++;
          $display("response with no job waiting for it");
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          assert (rsp_status_o === exp.status) else begin
            err_count++;
            $display("** Error rsp_status_o: got %h, expected %h", rsp_status_o, exp.status);
          end
          assert (rsp_addr_o === exp.addr) else begin
            err_count++;
            $display("** Error rsp_addr_o: got %h, expected %h", rsp_addr_o, exp.addr);
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------

  initial begin : main_sequence
    int unsigned          t;
    int unsigned          grants_before;
    logic [DataWidth-1:0] rd;
    job_src_i   = '0;
    job_dst_i   = '0;
    job_len_i   = '0;
    job_valid_i = 1'b0;
    in_req_i    = 1'b0;
    in_we_i     = 1'b0;
    in_addr_i   = '0;
    in_wdata_i  = '0;
    for (int unsigned i = 0; i < ExtWords; i++) begin
      ext_mem[i]    = ext_fill(i);
      ext_shadow[i] = ext_fill(i);
    end
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (reset && t < Timeout);
    assert (!reset) else begin
      fail_count++;
      $display("timeout: reset never released");
    end
    @(negedge clk);
    assert (job_ready_o === 1'b1) else begin
      err_count++;
      $display("** Error job_ready_o: got %h, expected %h", job_ready_o, 1'b1);
    end
    assert (rsp_valid_o === 1'b0 && ext_req_o === 1'b0 && in_rvalid_o === 1'b0) else begin
      err_count++;
      $display("** Error rsp_valid_o/ext_req_o/in_rvalid_o: got %h%h%h, expected 000",
               rsp_valid_o, ext_req_o, in_rvalid_o);
    end

    // preload local memory through the inbound port
    for (int unsigned i = 0; i < MemWords; i++) begin
      local_shadow[i] = stim_bits(32);
      write_local(i, local_shadow[i]);
    end
    @(posedge clk);
    in_req_i <= 1'b0;
    in_we_i  <= 1'b0;

    // local to local, local to external, external to local
    send_job(16'h0000, 16'h0040, 8'd16);
    wait_responses();
    send_job(16'h0010, 16'h1000, 8'd16);
    wait_responses();
    send_job(16'h2000, 16'h0080, 8'd16);
    wait_responses();

    // bus errors on a write and on a read at the error boundary
    send_job(16'h0020, 16'hEFFE, 8'd5);
    send_job(16'hEFFE, 16'h00C0, 8'd4);
    wait_responses();

    // zero length must not touch the external bus
    grants_before = ext_access_count;
    send_job(16'h2000, 16'h3000, 8'd0);
    wait_responses();
    assert (ext_access_count == grants_before) else begin
      fail_count++;
      $display("zero-length job made an external access");
    end

    // burst against a stalled, then randomly ready response port
    saw_full = 1'b0;
    ready_mode <= 1;
    for (int j = 0; j < 12; j++) begin
      send_job(AddrWidth'(stim_bits(8)),
               {(stim_bits(1) != 0) ? 8'h10 : 8'h00, 8'(stim_bits(8))},
               LenWidth'(stim_bits(2)));
    end
    ready_mode <= 2;
    wait_responses();
    ready_mode <= 0;
    assert (saw_full) else begin
      fail_count++;
      $display("job_ready_o never dropped during the burst");
    end
    assert (rsp_count == job_count) else begin
      fail_count++;
      $display("%0d jobs accepted but %0d responses seen", job_count, rsp_count);
    end

    // final memory contents
    for (int unsigned i = 0; i < MemWords; i++) begin
      read_local(i, rd);
      assert (rd === local_shadow[i]) else begin
        err_count++;
        $display("** Error in_rdata_o[%h]: got %h, expected %h", i, rd, local_shadow[i]);
      end
    end
    for (int unsigned i = 0; i < ExtWords; i++) begin
      assert (ext_mem[i] === ext_shadow[i]) else begin
        err_count++;
        $display("** Error ext_wdata_o at %h: got %h, expected %h", i, ext_mem[i], ext_shadow[i]);
      end
    end

    $display("value errors: %0d, other failures: %0d, responses: %0d",
             err_count, fail_count, rsp_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tb.f */
common/dma_node_pkg.sv
dma/dma_fifo.sv
dma/dma_backend.sv
design/dma_addr_demux.sv
design/node_mem.sv
design/dma_node.sv
tests/tb_clk_gen.sv
tests/tb_dma_node.sv
